/* source/uart_cfg.svh */
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// payload width of one frame
`define UART_DATA_BITS 8

// tx_clk cycles per serial bit
`define UART_CLKS_PER_BIT 8

// flip-flops in the receive synchronizer chain
`define UART_SYNC_STAGES 3

// parity sense, 0 even and 1 odd
`define UART_PARITY_ODD 0

`endif

/* source/uart_pkg.sv */
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

	// one payload byte
	typedef logic [`UART_DATA_BITS-1:0] data_t;

	// data bit index inside a frame
	typedef logic [3:0] bit_cnt_t;

	// clocks inside one bit time
	typedef logic [3:0] baud_cnt_t;

	typedef enum logic [2:0] {
		TX_IDLE,   // line high, waiting for send
		TX_START,  // start bit on the line
		TX_DATA,   // data bits, lsb first
		TX_PARITY, // parity bit
		TX_STOP    // stop bit
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,   // hunting for a start edge
		RX_START,  // waiting for the start bit middle
		RX_DATA,   // collecting data bits
		RX_PARITY, // parity bit check
		RX_STOP    // stop bit check
	} rx_state_e;

	typedef struct packed {
		data_t data;  // received byte
		logic  error; // parity mismatch or low stop bit
	} rx_result_t;

endpackage

`default_nettype wire

/* source/uart_tx.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_tx (
	input  wire              tx_clk,
	input  wire              reset_tx,
	input  wire              i_send,   // one cycle send strobe
	input  uart_pkg::data_t  i_data,   // byte taken with an accepted send
	output logic             o_busy,   // high for the whole frame
	output logic             o_serial  // line output that idles high
);

	import uart_pkg::*;

	localparam int        FRAME_BITS = `UART_DATA_BITS + 3;                  // start, data, parity, stop
	localparam baud_cnt_t BAUD_LAST  = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);  // last clock of a bit
	localparam bit_cnt_t  DATA_LAST  = bit_cnt_t'(`UART_DATA_BITS - 1);      // index of the msb
	localparam logic      PARITY_ODD = (`UART_PARITY_ODD != 0);

	tx_state_e             state_q;
	baud_cnt_t             baud_q;   // clocks into the current bit
	bit_cnt_t              bit_q;    // data bit being sent
	logic [FRAME_BITS-2:0] frame_q;  // bits after the start bit, lsb goes out next

	logic parity;   // parity bit of the incoming byte
	logic load;     // send accepted this cycle
	logic bit_end;  // last clock of the current bit

	assign parity  = (^i_data) ^ PARITY_ODD;       // even sense flipped for odd
	assign load    = (state_q == TX_IDLE) && i_send; // strobe while busy is dropped
	assign bit_end = (state_q != TX_IDLE) && (baud_q == BAUD_LAST);
	assign o_busy  = (state_q != TX_IDLE);

	// frame shift register holds the byte for the whole frame
	always_ff @(posedge tx_clk) begin
		if (load) begin
			frame_q <= {1'b1, parity, i_data};          // stop, parity, data
		end else if (bit_end) begin
			frame_q <= {1'b1, frame_q[FRAME_BITS-2:1]}; // shift in idle ones
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q  <= TX_IDLE;
			baud_q   <= '0;
			bit_q    <= '0;
			o_serial <= 1'b1;  // idle line
		end else begin
			// bit pacing
			if (load || bit_end) begin
				baud_q <= '0;
			end else if (o_busy) begin
				baud_q <= baud_q + 1'b1;
			end

			// line register follows the frame
			if (load) begin
				o_serial <= 1'b0;        // start bit at the next edge
			end else if (bit_end) begin
				o_serial <= frame_q[0];  // next bit of the frame
			end

			case (state_q)
				TX_IDLE: begin
					if (load) begin
						state_q <= TX_START;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state_q <= TX_DATA;
						bit_q   <= '0;  // first data bit
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						if (bit_q == DATA_LAST) begin
							state_q <= TX_PARITY;
						end else begin
							bit_q <= bit_q + 1'b1;
						end
					end
				end
				TX_PARITY: begin
					if (bit_end) begin
						state_q <= TX_STOP;
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state_q <= TX_IDLE;  // busy drops after the last stop clock
					end
				end
				default: state_q <= TX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/uart_rx_sampler.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_rx_sampler (
	input  wire  tx_clk,
	input  wire  reset_tx,
	input  wire  i_serial,  // raw line input
	input  wire  i_hunt,    // deframer is idle
	output logic o_line,    // synchronized line
	output logic o_sample   // strobe in the middle of a bit
);

	import uart_pkg::*;

	localparam int        SYNC_STAGES = `UART_SYNC_STAGES;
	localparam baud_cnt_t HALF_LOAD   = baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1);  // to the bit middle
	localparam baud_cnt_t FULL_LOAD   = baud_cnt_t'(`UART_CLKS_PER_BIT - 1);      // one bit time

	logic [SYNC_STAGES-1:0] sync_q;  // msb is the oldest stage
	baud_cnt_t              cnt_q;   // clocks to the next sample

	assign o_line = sync_q[SYNC_STAGES-1];

	// counter expiry outside hunt marks a bit middle
	assign o_sample = !i_hunt && (cnt_q == '0);

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			sync_q <= '1;  // line reads idle after reset
		end else begin
			sync_q <= {sync_q[SYNC_STAGES-2:0], i_serial};
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			cnt_q <= '0;
		end else if (i_hunt) begin
			if (o_line) begin
				cnt_q <= '0;         // idle line, held clear
			end else begin
				cnt_q <= HALF_LOAD;  // start edge seen
			end
		end else if (cnt_q == '0) begin
			cnt_q <= FULL_LOAD;      // sample now, next one a bit later
		end else begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/uart_rx_deframer.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_rx_deframer (
	input  wire                  tx_clk,
	input  wire                  reset_tx,
	input  wire                  i_line,    // synchronized line
	input  wire                  i_sample,  // bit middle strobe
	output logic                 o_hunt,    // idle, sampler looks for an edge
	output uart_pkg::rx_result_t o_result,  // last received frame
	output logic                 o_valid    // one cycle pulse on a new result
);

	import uart_pkg::*;

	localparam bit_cnt_t DATA_LAST  = bit_cnt_t'(`UART_DATA_BITS - 1);
	localparam int       DATA_BITS  = `UART_DATA_BITS;
	localparam logic     PARITY_ODD = (`UART_PARITY_ODD != 0);

	rx_state_e state_q;
	bit_cnt_t  bit_q;     // data bit being collected
	data_t     shift_q;   // bits enter at the msb, lsb first
	logic      parity_q;  // running xor of data bits
	logic      par_err_q; // parity bit disagreed

	assign o_hunt = (state_q == RX_IDLE);

	// payload path
	always_ff @(posedge tx_clk) begin
		if (i_sample) begin
			case (state_q)
				RX_START: begin
					parity_q <= PARITY_ODD;  // odd sense starts inverted
				end
				RX_DATA: begin
					shift_q  <= {i_line, shift_q[DATA_BITS-1:1]};
					parity_q <= parity_q ^ i_line;
				end
				RX_PARITY: begin
					par_err_q <= parity_q ^ i_line;  // nonzero means a mismatch
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge tx_clk) begin
		if (reset_tx) begin
			state_q  <= RX_IDLE;
			bit_q    <= '0;
			o_result <= '0;
			o_valid  <= 1'b0;
		end else begin
			o_valid <= 1'b0;  // pulse only
			case (state_q)
				RX_IDLE: begin
					if (!i_line) begin
						state_q <= RX_START;  // sampler loaded half a bit
					end
				end
				RX_START: begin
					if (i_sample) begin
						if (i_line) begin
							state_q <= RX_IDLE;  // glitch, not a start bit
						end else begin
							state_q <= RX_DATA;
							bit_q   <= '0;
						end
					end
				end
				RX_DATA: begin
					if (i_sample) begin
						if (bit_q == DATA_LAST) begin
							state_q <= RX_PARITY;
						end else begin
							bit_q <= bit_q + 1'b1;
						end
					end
				end
				RX_PARITY: begin
					if (i_sample) begin
						state_q <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (i_sample) begin
						o_result.data  <= shift_q;
						o_result.error <= par_err_q || !i_line;  // stop bit must be high
						o_valid        <= 1'b1;
						state_q        <= RX_IDLE;
					end
				end
				default: state_q <= RX_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* source/uart_top.sv */
`default_nettype none

module uart_top (
	input  wire                  tx_clk,
	input  wire                  reset_tx,
	input  wire                  i_send,        // send strobe
	input  uart_pkg::data_t      i_tx_data,     // byte to send
	output logic                 o_tx_busy,     // frame in progress
	output logic                 o_serial_out,  // line out
	input  wire                  i_serial_in,   // line in
	output uart_pkg::rx_result_t o_rx,          // last received frame
	output logic                 o_rx_valid     // new frame pulse
);

	import uart_pkg::*;

	logic rx_line;    // synchronized receive line
	logic rx_sample;  // mid-bit strobe
	logic rx_hunt;    // receiver waiting for a start edge

	// transmit path
	uart_tx u_uart_tx (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_send   (i_send),
		.i_data   (i_tx_data),
		.o_busy   (o_tx_busy),
		.o_serial (o_serial_out)
	);

	// receive front end, edge search and bit timing
	uart_rx_sampler u_uart_rx_sampler (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_serial (i_serial_in),
		.i_hunt   (rx_hunt),
		.o_line   (rx_line),
		.o_sample (rx_sample)
	);

	// receive back end, framing and checks
	uart_rx_deframer u_uart_rx_deframer (
		.tx_clk   (tx_clk),
		.reset_tx (reset_tx),
		.i_line   (rx_line),
		.i_sample (rx_sample),
		.o_hunt   (rx_hunt),
		.o_result (o_rx),
		.o_valid  (o_rx_valid)
	);

endmodule

`default_nettype wire

/* test/uart_tb.sv */
`default_nettype none

`include "uart_cfg.svh"

module uart_tb;

	import uart_pkg::*;

	localparam int BIT_CLKS   = `UART_CLKS_PER_BIT;
	localparam int FRAME_BITS = `UART_DATA_BITS + 3;     // start, data, parity, stop
	localparam int FRAME_CLKS = FRAME_BITS * BIT_CLKS;   // 88 with the default config
	localparam int NUM_LOOP   = 200;

	logic       tx_clk;
	logic       reset_tx;
	logic       i_send;
	data_t      i_tx_data;
	logic       o_tx_busy;
	logic       o_serial_out;
	logic       line;        // serial line into the dut
	logic       loopback;    // line follows the transmitter
	logic       inject_bit;  // line level while frames are injected
	rx_result_t o_rx;
	logic       o_rx_valid;

	rx_result_t exp_q[$];   // results the receiver still owes
	int         valid_cnt;  // valid pulses seen
	int         send_cnt;   // send strobes given

	uart_top u_uart_top (
		.tx_clk       (tx_clk),
		.reset_tx     (reset_tx),
		.i_send       (i_send),
		.i_tx_data    (i_tx_data),
		.o_tx_busy    (o_tx_busy),
		.o_serial_out (o_serial_out),
		.i_serial_in  (line),
		.o_rx         (o_rx),
		.o_rx_valid   (o_rx_valid)
	);

	always #4 tx_clk = ~tx_clk;  // period 8

	assign line = loopback ? o_serial_out : inject_bit;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check_result(input rx_result_t exp, input rx_result_t act);
		if (act !== exp) begin
			abort_run($sformatf("** Error: o_rx expected %h actual %h", exp, act));
		end
	endtask

	task automatic check_line(input logic exp, input logic act, input string name);
		if (act !== exp) begin
			abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_busy(input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("** Error: o_tx_busy expected %h actual %h", exp, act));
		end
	endtask

	task automatic check_count(input int exp, input int act, input string name);
		if (act != exp) begin
			abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
		end
	endtask

	// parity bit as the line carries it, xor of the data bits
	function automatic logic model_parity(input data_t d);
		logic p;
		p = (`UART_PARITY_ODD != 0);  // odd sense starts at one
		for (int i = 0; i < `UART_DATA_BITS; i++) begin
			p = p ^ d[i];
		end
		return p;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge tx_clk);
	endtask

	// called on a falling edge with the transmitter idle
	task automatic send_byte(input data_t d, input logic expect_rx);
		rx_result_t r;
		r.data    = d;
		r.error   = 1'b0;
		i_send    = 1'b1;
		i_tx_data = d;
		if (expect_rx) begin
			exp_q.push_back(r);
		end
		@(negedge tx_clk);
		i_send = 1'b0;  // one cycle strobe
		send_cnt++;
	endtask

	task automatic wait_busy_low();
		int n;
		n = 0;
		while (o_tx_busy) begin
			@(negedge tx_clk);
			n++;
			if (n > FRAME_CLKS + 8) begin
				abort_run("timeout: o_tx_busy never fell");
			end
		end
	endtask

	task automatic wait_rx_drained();
		int n;
		n = 0;
		while (exp_q.size() > 0) begin
			@(negedge tx_clk);
			n++;
			if (n > 3 * FRAME_CLKS) begin
				abort_run("timeout: o_rx_valid never came for a sent frame");
			end
		end
	endtask

	// drives one frame on the line, each bit held a full bit time
	task automatic inject_frame(input data_t d, input logic par_flip, input logic stop_bad);
		logic [FRAME_BITS-1:0] bits;
		rx_result_t            r;
		bits    = {!stop_bad, model_parity(d) ^ par_flip, d, 1'b0};
		r.data  = d;
		r.error = par_flip | stop_bad;
		exp_q.push_back(r);
		for (int k = 0; k < FRAME_BITS; k++) begin
			inject_bit = bits[k];
			wait_cycles(BIT_CLKS);
		end
		inject_bit = 1'b1;  // back to idle
	endtask

	// every valid pulse takes the oldest expected result
	always @(negedge tx_clk) begin
		if (!reset_tx && o_rx_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("o_rx_valid pulsed while no frame was expected");
			end else begin
				check_result(exp_q.pop_front(), o_rx);
				valid_cnt++;
			end
		end
	end

	initial begin
		data_t                 d;
		logic [FRAME_BITS-1:0] exp_frame;
		void'($urandom(90));
		tx_clk     = 1'b0;
		reset_tx   = 1'b1;
		i_send     = 1'b0;
		i_tx_data  = '0;
		loopback   = 1'b1;
		inject_bit = 1'b1;
		valid_cnt  = 0;
		send_cnt   = 0;
		wait_cycles(2);
		reset_tx = 1'b0;

		// idle outputs after reset
		check_result('0, o_rx);
		for (int c = 0; c < 20; c++) begin
			check_busy(1'b0, o_tx_busy);
			check_line(1'b1, o_serial_out, "o_serial_out");
			check_line(1'b0, o_rx_valid, "o_rx_valid");
			@(negedge tx_clk);
		end

		// transmit waveform, mid-bit samples and busy length
		d         = data_t'($urandom);
		exp_frame = {1'b1, model_parity(d), d, 1'b0};
		send_byte(d, 1'b1);
		for (int t = 0; t < FRAME_CLKS; t++) begin
			if (t % BIT_CLKS == BIT_CLKS / 2) begin
				check_line(exp_frame[t / BIT_CLKS], o_serial_out, "o_serial_out");
			end
			check_busy(1'b1, o_tx_busy);
			@(negedge tx_clk);
		end
		check_busy(1'b0, o_tx_busy);  // 88 cycles after the send
		wait_rx_drained();

		// back-to-back loopback
		valid_cnt = 0;
		send_cnt  = 0;
		for (int n = 0; n < NUM_LOOP; n++) begin
			wait_busy_low();
			send_byte(data_t'($urandom), 1'b1);
		end
		wait_busy_low();
		wait_rx_drained();
		check_count(send_cnt, valid_cnt, "valid count");

		// a send during a frame is dropped
		valid_cnt = 0;
		d         = data_t'($urandom);
		send_byte(d, 1'b1);
		wait_cycles(3 * BIT_CLKS);
		send_byte(~d, 1'b0);
		wait_busy_low();
		wait_rx_drained();
		wait_cycles(FRAME_CLKS);  // room for a stray second frame
		check_count(1, valid_cnt, "valid count");

		// injected parity and stop bit errors
		loopback = 1'b0;
		wait_cycles(2 * BIT_CLKS);
		for (int n = 0; n < 4; n++) begin
			inject_frame(data_t'($urandom), 1'b1, 1'b0);
			wait_cycles(2 * BIT_CLKS);
			inject_frame(data_t'($urandom), 1'b0, 1'b1);
			wait_cycles(2 * BIT_CLKS);
		end
		wait_rx_drained();

		// short low glitch, then a good frame
		valid_cnt  = 0;
		inject_bit = 1'b0;
		wait_cycles(BIT_CLKS / 4);  // under half a bit
		inject_bit = 1'b1;
		wait_cycles(2 * FRAME_CLKS);
		check_count(0, valid_cnt, "valid count");
		inject_frame(data_t'($urandom), 1'b0, 1'b0);
		wait_rx_drained();
		check_count(1, valid_cnt, "valid count");

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+source
source/uart_pkg.sv
source/uart_tx.sv
source/uart_rx_sampler.sv
source/uart_rx_deframer.sv
source/uart_top.sv
test/uart_tb.sv
